// File: ex_alu.sv
// Combinational ALU for the execute stage
// Add, subtract, logic, shifts, set-less-than and branch compares

`timescale 1ns/1ps

module ex_alu (
  input  ex_op_pkg::alu_op_e operator_i,
  input  logic [31:0]        operand_a_i,
  input  logic [31:0]        operand_b_i,
  output logic [31:0]        result_o,
  output logic               cmp_result_o
);

  logic        sub;
  logic        cmp_signed;
  logic [32:0] a_ext;
  logic [32:0] b_ext;
  logic [32:0] b_mux;
  logic [32:0] adder;
  logic        lt;
  logic        eq;
  logic        cmp_bit;
  logic [4:0]  shamt;

  ////////////////////////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////////////////////////

  // Everything except ADD goes through the adder as a subtraction
  assign sub        = (operator_i != ex_op_pkg::ADD);
  assign cmp_signed = operator_i inside {ex_op_pkg::LT, ex_op_pkg::GE, ex_op_pkg::SLT};

  // Extra top bit is the sign for signed compares, zero for unsigned
  assign a_ext = {cmp_signed & operand_a_i[31], operand_a_i};
  assign b_ext = {cmp_signed & operand_b_i[31], operand_b_i};
  assign b_mux = sub ? ~b_ext : b_ext;
  assign adder = a_ext + b_mux + {32'b0, sub};

  // Bit 32 of the difference is the less-than flag
  assign lt = adder[32];
  assign eq = (adder[31:0] == 32'b0);

  always_comb begin
    case (operator_i)
      ex_op_pkg::EQ:  cmp_bit = eq;
      ex_op_pkg::NE:  cmp_bit = !eq;
      ex_op_pkg::GE,
      ex_op_pkg::GEU: cmp_bit = !lt;
      default:        cmp_bit = lt;
    endcase
  end

  // Compare flag only for the branch comparison operators
  assign cmp_result_o = ex_op_pkg::is_cmp_op(operator_i) ? cmp_bit : 1'b0;

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////

  assign shamt = operand_b_i[4:0];

  always_comb begin
    case (operator_i)
      ex_op_pkg::ADD,
      ex_op_pkg::SUB: begin
        result_o = adder[31:0];
      end
      ex_op_pkg::AND: begin
        result_o = operand_a_i & operand_b_i;
      end
      ex_op_pkg::OR: begin
        result_o = operand_a_i | operand_b_i;
      end
      ex_op_pkg::XOR: begin
        result_o = operand_a_i ^ operand_b_i;
      end
      ex_op_pkg::SLL: begin
        result_o = operand_a_i << shamt;
      end
      ex_op_pkg::SRL: begin
        result_o = operand_a_i >> shamt;
      end
      ex_op_pkg::SRA: begin
        result_o = $unsigned($signed(operand_a_i) >>> shamt);
      end
      ex_op_pkg::SLT,
      ex_op_pkg::SLTU: begin
        result_o = {31'b0, cmp_bit};
      end
      // Branch compares only raise the flag
      default: begin
        result_o = 32'b0;
      end
    endcase
  end

endmodule

// File: ex_block.sv
// Execute stage with ALU and optional multiply/divide unit
// Holds the request while multdiv iterates and forms the result record

`timescale 1ns/1ps

module ex_block #(
  parameter bit RV32M = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  ex_data_pkg::ex_req_t req_i,
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  output ex_data_pkg::ex_rsp_t rsp_o
);

  logic [31:0] alu_result;
  logic        alu_cmp;
  logic        md_valid;
  logic [31:0] md_result;
  logic        md_illegal;
  logic        rsp_xfer;

  ex_alu u_alu (
    .operator_i   (req_i.alu_op),
    .operand_a_i  (req_i.operand_a),
    .operand_b_i  (req_i.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  assign rsp_xfer = rsp_valid_o && rsp_ready_i;

  if (RV32M) begin : gen_multdiv
    logic launched_q;
    logic md_done_q;
    logic md_start;
    logic md_busy;
    logic md_done;

    // Start once per request
    assign md_start = req_valid_i && req_i.is_md && !launched_q;

    ex_multdiv u_multdiv (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .start_i    (md_start),
      .operator_i (req_i.md_op),
      .op_a_i     (req_i.operand_a),
      .op_b_i     (req_i.operand_b),
      .busy_o     (md_busy),
      .done_o     (md_done),
      .result_o   (md_result)
    );

    // Done pulse is kept until the result leaves
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        launched_q <= 1'b0;
        md_done_q  <= 1'b0;
      end else begin
        if (rsp_xfer) begin
          launched_q <= 1'b0;
          md_done_q  <= 1'b0;
        end else begin
          if (md_start) begin
            launched_q <= 1'b1;
          end
          if (md_done) begin
            md_done_q <= 1'b1;
          end
        end
      end
    end

    assign md_valid   = md_done | md_done_q;
    assign md_illegal = 1'b0;

    // Operands must not move under a running multdiv
    req_hold_a: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      launched_q |-> $stable(req_i)
    );

    // A launched operation without result is still iterating
    md_busy_a: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      launched_q && !md_valid |-> md_busy
    );
  end else begin : gen_no_multdiv
    // Multiply/divide completes at once as illegal
    assign md_valid   = 1'b1;
    assign md_result  = 32'b0;
    assign md_illegal = 1'b1;
  end

  assign rsp_valid_o = req_valid_i && (req_i.is_md ? md_valid : 1'b1);
  assign req_ready_o = rsp_xfer;

  always_comb begin
    rsp_o.tag       = req_i.tag;
    rsp_o.result    = req_i.is_md ? md_result : alu_result;
    rsp_o.cmp_taken = !req_i.is_md && alu_cmp;
    rsp_o.illegal   = req_i.is_md && md_illegal;
  end

endmodule

// File: ex_data_pkg.sv
// Request and result records of the execution unit
// Tag width and packed structs exchanged between stages

package ex_data_pkg;

  // Width of the ordering tag
  localparam int unsigned TagW = 4;

  ////////////////////////////////////////////////////////////
  // Request record, 76 bits
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [TagW-1:0]     tag;
    logic                is_md;
    ex_op_pkg::alu_op_e  alu_op;
    ex_op_pkg::md_op_e   md_op;
    logic [31:0]         operand_a;
    logic [31:0]         operand_b;
  } ex_req_t;

  ////////////////////////////////////////////////////////////
  // Result record, 38 bits
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [TagW-1:0] tag;
    logic [31:0]     result;
    // Set for a taken branch comparison
    logic            cmp_taken;
    // Set when the operation class is not built
    logic            illegal;
  } ex_rsp_t;

endpackage

// File: ex_multdiv.sv
// Iterative multiplier and divider
// Shift-add multiply, restoring divide, sign fixup in a final cycle

`timescale 1ns/1ps

module ex_multdiv (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              start_i,
  input  ex_op_pkg::md_op_e operator_i,
  input  logic [31:0]       op_a_i,
  input  logic [31:0]       op_b_i,
  output logic              busy_o,
  output logic              done_o,
  output logic [31:0]       result_o
);

  // Control state
  logic        busy_q;
  logic        done_q;
  logic [5:0]  cnt_q;

  // Intermediate value register and operation context
  logic [63:0]       acc_q;
  logic [31:0]       opb_q;
  ex_op_pkg::md_op_e op_q;
  logic              neg_q;
  logic              neg_r_q;
  logic              div0_q;

  logic        a_neg;
  logic        b_neg;
  logic [31:0] a_abs;
  logic [31:0] b_abs;
  logic [32:0] mul_sum;
  logic [34:0] div_diff;
  logic [63:0] acc_step;
  logic [63:0] acc_fix;

  ////////////////////////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////////////////////////

  assign a_neg = ex_op_pkg::md_sign_a(operator_i) & op_a_i[31];
  assign b_neg = ex_op_pkg::md_sign_b(operator_i) & op_b_i[31];
  assign a_abs = a_neg ? -op_a_i : op_a_i;
  assign b_abs = b_neg ? -op_b_i : op_b_i;

  ////////////////////////////////////////////////////////////
  // One iteration and the final sign fix
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Multiply adds B when the low bit is set, then shifts right
    mul_sum  = {1'b0, acc_q[63:32]} + (acc_q[0] ? {1'b0, opb_q} : 33'd0);
    // Divide tries to subtract B from the remainder shifted left by one
    div_diff = {2'b0, acc_q[63:31]} - {3'b0, opb_q};
    if (ex_op_pkg::md_is_div(op_q)) begin
      if (!div_diff[34]) begin
        acc_step = {div_diff[31:0], acc_q[30:0], 1'b1};
      end else begin
        acc_step = {acc_q[62:0], 1'b0};
      end
    end else begin
      acc_step = {mul_sum, acc_q[31:1]};
    end
  end

  // Quotient of a divide by zero stays all ones.
  // Most negative by minus one needs no special case here.
  always_comb begin
    if (ex_op_pkg::md_is_div(op_q)) begin
      acc_fix[63:32] = neg_r_q ? -acc_q[63:32] : acc_q[63:32];
      acc_fix[31:0]  = div0_q ? 32'hffff_ffff : (neg_q ? -acc_q[31:0] : acc_q[31:0]);
    end else begin
      acc_fix = neg_q ? -acc_q : acc_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////

  // 32 iterations plus one fixup cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= 6'd0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= 6'd32;
      end else if (busy_q) begin
        if (cnt_q != 6'd0) begin
          cnt_q <= cnt_q - 6'd1;
        end else begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      acc_q   <= {32'b0, a_abs};
      opb_q   <= b_abs;
      op_q    <= operator_i;
      neg_q   <= a_neg ^ b_neg;
      neg_r_q <= a_neg;
      div0_q  <= ex_op_pkg::md_is_div(operator_i) && (op_b_i == 32'b0);
    end else if (busy_q) begin
      acc_q <= (cnt_q != 6'd0) ? acc_step : acc_fix;
    end
  end

  assign busy_o   = busy_q;
  assign done_o   = done_q;
  assign result_o = ex_op_pkg::md_res_high(op_q) ? acc_q[63:32] : acc_q[31:0];

  // No new operation while one iterates
  no_restart_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    start_i |-> !busy_o
  );

endmodule

// File: ex_op_pkg.sv
// Operator encodings for the execution unit
// ALU and multiply/divide operator enums plus class helper functions

package ex_op_pkg;

  // ALU operators, 4-bit encoding
  typedef enum logic [3:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    XOR  = 4'h4,
    SLL  = 4'h5,
    SRL  = 4'h6,
    SRA  = 4'h7,
    SLT  = 4'h8,
    SLTU = 4'h9,
    EQ   = 4'ha,
    NE   = 4'hb,
    LT   = 4'hc,
    GE   = 4'hd,
    LTU  = 4'he,
    GEU  = 4'hf
  } alu_op_e;

  // Multiply/divide operators, 3-bit encoding
  typedef enum logic [2:0] {
    MUL    = 3'h0,
    MULH   = 3'h1,
    MULHSU = 3'h2,
    MULHU  = 3'h3,
    DIV    = 3'h4,
    DIVU   = 3'h5,
    REM    = 3'h6,
    REMU   = 3'h7
  } md_op_e;

  // Branch comparisons only, SLT and SLTU are not included
  function automatic logic is_cmp_op(alu_op_e op);
    return op inside {EQ, NE, LT, GE, LTU, GEU};
  endfunction

  function automatic logic md_is_div(md_op_e op);
    return op inside {DIV, DIVU, REM, REMU};
  endfunction

  // Operand A is treated as signed
  function automatic logic md_sign_a(md_op_e op);
    return op inside {MUL, MULH, MULHSU, DIV, REM};
  endfunction

  // Operand B is treated as signed
  function automatic logic md_sign_b(md_op_e op);
    return op inside {MUL, MULH, DIV, REM};
  endfunction

  // Result taken from upper half of the 64-bit register
  function automatic logic md_res_high(md_op_e op);
    return op inside {MULH, MULHSU, MULHU, REM, REMU};
  endfunction

endpackage

// File: ex_pipe_reg.sv
// Single-entry valid/ready register slice
// Payload type is a parameter, used for issue and result stages

`timescale 1ns/1ps

module ex_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,

  // Upstream side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,

  // Downstream side
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  payload_t data_q;

  // Accept when empty or when the held entry leaves this cycle
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // A stalled entry keeps its valid and its payload
  stall_hold_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
  );

endmodule

// File: ex_unit_top.sv
// Top level of the integer execution unit
// Issue register, execute block and result register in a chain

`timescale 1ns/1ps

module ex_unit_top #(
  parameter bit RV32M = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  ex_data_pkg::ex_req_t req_i,
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  output ex_data_pkg::ex_rsp_t rsp_o
);

  // Issue register to execute block
  logic                 iss_valid;
  logic                 iss_ready;
  ex_data_pkg::ex_req_t iss_req;

  // Execute block to result register
  logic                 ex_valid;
  logic                 ex_ready;
  ex_data_pkg::ex_rsp_t ex_rsp;

  ex_pipe_reg #(
    .payload_t (ex_data_pkg::ex_req_t)
  ) u_issue_reg (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .in_data_i   (req_i),
    .out_valid_o (iss_valid),
    .out_ready_i (iss_ready),
    .out_data_o  (iss_req)
  );

  ex_block #(
    .RV32M (RV32M)
  ) u_ex_block (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (iss_valid),
    .req_ready_o (iss_ready),
    .req_i       (iss_req),
    .rsp_valid_o (ex_valid),
    .rsp_ready_i (ex_ready),
    .rsp_o       (ex_rsp)
  );

  ex_pipe_reg #(
    .payload_t (ex_data_pkg::ex_rsp_t)
  ) u_result_reg (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (ex_valid),
    .in_ready_o  (ex_ready),
    .in_data_i   (ex_rsp),
    .out_valid_o (rsp_valid_o),
    .out_ready_i (rsp_ready_i),
    .out_data_o  (rsp_o)
  );

endmodule

// File: files.f
ex_op_pkg.sv
ex_data_pkg.sv
ex_pipe_reg.sv
ex_alu.sv
ex_multdiv.sv
ex_block.sv
ex_unit_top.sv
tb_ex_unit.sv

// File: tb_ex_unit.sv
// Testbench for the integer execution unit
// Stimulus, reference model, response monitor and report

`timescale 1ns/1ps

module tb_ex_unit;

  logic                 clk_i;
  logic                 arst_n_i;
  logic                 req_valid_i;
  logic                 req_ready_o;
  ex_data_pkg::ex_req_t req_i;
  logic                 rsp_valid_o;
  logic                 rsp_ready_i;
  ex_data_pkg::ex_rsp_t rsp_o;

  // Scoreboard state
  ex_data_pkg::ex_rsp_t             exp_q[$];
  logic [ex_data_pkg::TagW-1:0]     tx_tag = '0;
  logic [ex_data_pkg::TagW-1:0]     rx_tag = '0;
  logic [31:0]                      stim_state = 32'hdb8a;
  logic [31:0]                      bp_state = ~32'hdb8a;
  logic                             bp_en = 1'b0;
  logic                             aborted = 1'b0;
  int                               err_count = 0;
  int                               test_err_base = 0;
  int                               pass_count = 0;
  int                               fail_count = 0;

  // Zero, all ones, most negative, most positive, one, shift amount 31
  logic [31:0] edge_v [6] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
                              32'h1, 32'h1f};

  ex_unit_top #(
    .RV32M (1'b1)
  ) ex_unit_top_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #2;
      clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rnd();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  function automatic ex_data_pkg::ex_rsp_t ref_rsp(input ex_data_pkg::ex_req_t req);
    ex_data_pkg::ex_rsp_t rsp;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [63:0]        p_ss;
    logic [63:0]        p_su;
    logic [63:0]        p_uu;
    logic signed [31:0] q_s;
    logic signed [31:0] r_s;
    logic               lt_s;
    logic               lt_u;
    logic               eq;
    logic               ovf;
    a    = req.operand_a;
    b    = req.operand_b;
    rsp  = '0;
    rsp.tag = req.tag;
    // Extended operands, product kept modulo 2^64
    p_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    p_su = {{32{a[31]}}, a} * {32'b0, b};
    p_uu = {32'b0, a} * {32'b0, b};
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    eq   = (a == b);
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    // Signed quotient and remainder of the regular case
    if (b != 0 && !ovf) begin
      q_s = $signed(a) / $signed(b);
      r_s = $signed(a) % $signed(b);
    end else begin
      q_s = '0;
      r_s = '0;
    end
    if (req.is_md) begin
      case (req.md_op)
        ex_op_pkg::MUL:    rsp.result = p_uu[31:0];
        ex_op_pkg::MULH:   rsp.result = p_ss[63:32];
        ex_op_pkg::MULHSU: rsp.result = p_su[63:32];
        ex_op_pkg::MULHU:  rsp.result = p_uu[63:32];
        ex_op_pkg::DIV:    rsp.result = (b == 0) ? 32'hffff_ffff : (ovf ? a : q_s);
        ex_op_pkg::DIVU:   rsp.result = (b == 0) ? 32'hffff_ffff : a / b;
        ex_op_pkg::REM:    rsp.result = (b == 0) ? a : (ovf ? 32'h0 : r_s);
        default:           rsp.result = (b == 0) ? a : a % b;
      endcase
    end else begin
      case (req.alu_op)
        ex_op_pkg::ADD:  rsp.result = a + b;
        ex_op_pkg::SUB:  rsp.result = a - b;
        ex_op_pkg::AND:  rsp.result = a & b;
        ex_op_pkg::OR:   rsp.result = a | b;
        ex_op_pkg::XOR:  rsp.result = a ^ b;
        ex_op_pkg::SLL:  rsp.result = a << b[4:0];
        ex_op_pkg::SRL:  rsp.result = a >> b[4:0];
        ex_op_pkg::SRA:  rsp.result = $signed(a) >>> b[4:0];
        ex_op_pkg::SLT:  rsp.result = {31'b0, lt_s};
        ex_op_pkg::SLTU: rsp.result = {31'b0, lt_u};
        ex_op_pkg::EQ:   rsp.cmp_taken = eq;
        ex_op_pkg::NE:   rsp.cmp_taken = !eq;
        ex_op_pkg::LT:   rsp.cmp_taken = lt_s;
        ex_op_pkg::GE:   rsp.cmp_taken = !lt_s;
        ex_op_pkg::LTU:  rsp.cmp_taken = lt_u;
        default:         rsp.cmp_taken = !lt_u;
      endcase
    end
    return rsp;
  endfunction

  function automatic ex_data_pkg::ex_req_t mk_req(input logic is_md, input int op,
                                                  input logic [31:0] a, input logic [31:0] b);
    ex_data_pkg::ex_req_t req;
    req           = '0;
    req.is_md     = is_md;
    req.alu_op    = ex_op_pkg::alu_op_e'(op[3:0]);
    req.md_op     = ex_op_pkg::md_op_e'(op[2:0]);
    req.operand_a = a;
    req.operand_b = b;
    return req;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("mismatch %s expected 0x%h actual 0x%h", name, exp_v, act_v);
    err_count++;
  endtask

  task automatic check_rsp_data(input ex_data_pkg::ex_rsp_t exp_rsp,
                                input ex_data_pkg::ex_rsp_t act_rsp);
    if (act_rsp.tag !== exp_rsp.tag) begin
      report_mismatch("rsp_o.tag", exp_rsp.tag, act_rsp.tag);
    end
    if (act_rsp.result !== exp_rsp.result) begin
      report_mismatch("rsp_o.result", exp_rsp.result, act_rsp.result);
    end
    if (act_rsp.cmp_taken !== exp_rsp.cmp_taken) begin
      report_mismatch("rsp_o.cmp_taken", exp_rsp.cmp_taken, act_rsp.cmp_taken);
    end
    if (act_rsp.illegal !== exp_rsp.illegal) begin
      report_mismatch("rsp_o.illegal", exp_rsp.illegal, act_rsp.illegal);
    end
  endtask

  task automatic check_rsp_order(input logic [ex_data_pkg::TagW-1:0] exp_tag,
                                 input logic [ex_data_pkg::TagW-1:0] act_tag);
    if (act_tag !== exp_tag) begin
      report_mismatch("rsp_o.tag order", exp_tag, act_tag);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      report_mismatch(name, exp_v, act_v);
    end
  endtask

  // Responses are sampled at the falling edge before the transfer edge
  initial begin : rsp_monitor
    ex_data_pkg::ex_rsp_t exp_rsp;
    forever begin
      @(negedge clk_i);
      if (arst_n_i && rsp_valid_o && rsp_ready_i) begin
        check_rsp_order(rx_tag, rsp_o.tag);
        rx_tag++;
        if (exp_q.size() == 0) begin
          $display("response with tag 0x%h arrived with no request pending", rsp_o.tag);
          err_count++;
        end else begin
          exp_rsp = exp_q.pop_front();
          check_rsp_data(exp_rsp, rsp_o);
        end
      end
    end
  end

  // Random low and high periods on rsp_ready_i
  initial begin : ready_driver
    int hold;
    hold        = 0;
    rsp_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      if (!bp_en) begin
        rsp_ready_i = 1'b1;
      end else if (hold != 0) begin
        hold--;
      end else begin
        bp_state    = xorshift32(bp_state);
        rsp_ready_i = !rsp_ready_i;
        hold        = rsp_ready_i ? int'(bp_state[2:0]) : int'(bp_state[5:4]);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Driver tasks
  ////////////////////////////////////////////////////////////

  // Called and returns 1 ns after a rising edge
  task automatic send_req(input ex_data_pkg::ex_req_t req);
    int cycles;
    if (!aborted) begin
      req.tag     = tx_tag;
      req_i       = req;
      req_valid_i = 1'b1;
      cycles      = 0;
      @(negedge clk_i);
      while (!req_ready_o && cycles < 200) begin
        @(negedge clk_i);
        cycles++;
      end
      if (req_ready_o) begin
        exp_q.push_back(ref_rsp(req));
        tx_tag++;
      end else begin
        $display("request with tag 0x%h was not accepted within 200 cycles", req.tag);
        err_count++;
        aborted = 1'b1;
      end
      @(posedge clk_i);
      #1;
      req_valid_i = 1'b0;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && !aborted) begin
      @(negedge clk_i);
      cycles++;
      if (cycles >= 200 && exp_q.size() != 0) begin
        $display("%0d responses still missing after 200 cycles", exp_q.size());
        err_count++;
        aborted = 1'b1;
      end
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic end_test(input string name);
    wait_drain();
    if (err_count == test_err_base && !aborted) begin
      pass_count++;
      $display("test %s: pass", name);
    end else begin
      fail_count++;
      $display("test %s: FAIL with %0d errors", name, err_count - test_err_base);
    end
    test_err_base = err_count;
  endtask

  // Edge grid, then random pairs with a varied divisor magnitude
  task automatic sweep_ops(input logic is_md, input int first_op, input int last_op,
                           input int n_rand);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    int          op;
    int          i;
    int          j;
    for (op = first_op; op <= last_op; op++) begin
      for (i = 0; i < 6; i++) begin
        for (j = 0; j < 6; j++) begin
          send_req(mk_req(is_md, op, edge_v[i], edge_v[j]));
        end
      end
      for (i = 0; i < n_rand; i++) begin
        a = rnd();
        c = rnd();
        b = rnd() >> c[4:0];
        send_req(mk_req(is_md, op, a, b));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main_seq
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    int          i;
    int          j;
    req_valid_i = 1'b0;
    req_i       = '0;
    arst_n_i    = 1'b0;
    for (i = 0; i < 4; i++) begin
      @(posedge clk_i);
      #1;
      check_flag("rsp_valid_o", 1'b0, rsp_valid_o);
      check_flag("req_ready_o", 1'b1, req_ready_o);
    end
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag("rsp_valid_o", 1'b0, rsp_valid_o);
    check_flag("req_ready_o", 1'b1, req_ready_o);
    end_test("reset state");

    sweep_ops(1'b0, 0, 7, 25);
    end_test("alu arithmetic, logic and shifts");
    sweep_ops(1'b0, 8, 15, 8);
    end_test("comparisons and branch flag");
    sweep_ops(1'b1, 0, 3, 10);
    end_test("multiply variants");
    sweep_ops(1'b1, 4, 7, 10);
    for (i = 4; i < 8; i++) begin
      for (j = 0; j < 4; j++) begin
        a = rnd();
        send_req(mk_req(1'b1, i, a, 32'h0));
      end
    end
    end_test("divide variants and corner cases");

    // Mixed stream, about one in four requests is multiply/divide
    @(negedge clk_i);
    bp_en = 1'b1;
    @(posedge clk_i);
    #1;
    for (i = 0; i < 300; i++) begin
      r = rnd();
      a = rnd();
      b = rnd() >> r[12:8];
      send_req(mk_req(r[1:0] == 2'b00, int'(r[7:4]), a, b));
      if (r[2]) begin
        idle_cycles(int'(r[14:13]));
      end
    end
    @(negedge clk_i);
    bp_en = 1'b0;
    @(posedge clk_i);
    #1;
    end_test("mixed stream with back-pressure");

    $display("tests passed %0d, tests failed %0d, errors %0d", pass_count, fail_count,
             err_count);
    if (fail_count == 0 && err_count == 0 && !aborted) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
